// File: source/cad_pkg.sv
// Convolution engine shared definitions
// Element and accumulator widths, data types and controller states

package cad_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  // Image and kernel elements are signed bytes
  localparam int PIX_W = 8;
  // 25 products of two bytes fit in 20 bits with sign
  localparam int ACC_W = 20;
  // Kernel side length
  localparam int K_SIZE = 5;

  // ------------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------------
  typedef logic signed [PIX_W-1:0] pix_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD_IMG,
    ST_LOAD_KER,
    ST_CONV,
    ST_WAIT_RES
  } ctrl_state_t;

endpackage

// File: source/cad_buffer.sv
// Image and kernel storage
// Register arrays written one byte per transfer; each cycle registers five
// consecutive image pixels of one row and one full kernel row

`timescale 1ns/1ps

module cad_buffer import cad_pkg::*; #(
  parameter int IMG_SIZE = 8
) (
  input  logic                        clk,
  input  pix_t                        in_data,
  input  logic                        wr_en,
  input  logic                        wr_ker,
  input  logic [$clog2(IMG_SIZE)-1:0] wr_row,
  input  logic [$clog2(IMG_SIZE)-1:0] wr_col,
  input  logic [$clog2(IMG_SIZE)-1:0] rd_row,
  input  logic [$clog2(IMG_SIZE)-1:0] rd_col,
  input  logic [2:0]                  ker_row,
  output pix_t                        img_row      [K_SIZE],
  output pix_t                        ker_row_data [K_SIZE]
);

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  pix_t img_mem [IMG_SIZE][IMG_SIZE];
  pix_t ker_mem [K_SIZE][K_SIZE];

  // Write port shared by image and kernel
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      if (wr_ker)
        ker_mem[wr_row[2:0]][wr_col[2:0]] <= in_data;
      else
        img_mem[wr_row][wr_col] <= in_data;
    end
  end

  // --------------------------------------------------------------------------
  // Five-wide registered read
  // --------------------------------------------------------------------------
  // rd_col never exceeds IMG_SIZE-5 during a scan
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < K_SIZE; k++)
    begin
      img_row[k]      <= img_mem[rd_row][rd_col + k];
      ker_row_data[k] <= ker_mem[ker_row][k];
    end
  end

endmodule

// File: source/cad_ctrl.sv
// Convolution engine controller
// FSM for image and kernel loading, pool window scanning and result
// hand-off; issues buffer addresses and delayed MAC control flags

`timescale 1ns/1ps

module cad_ctrl import cad_pkg::*; #(
  parameter int IMG_SIZE = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  logic                        res_valid,
  input  logic                        res_ready,
  output logic                        in_ready,
  output logic                        wr_en,
  output logic                        wr_ker,
  output logic [$clog2(IMG_SIZE)-1:0] wr_row,
  output logic [$clog2(IMG_SIZE)-1:0] wr_col,
  output logic [$clog2(IMG_SIZE)-1:0] rd_row,
  output logic [$clog2(IMG_SIZE)-1:0] rd_col,
  output logic [2:0]                  ker_row,
  output logic                        tap_valid,
  output logic                        tap_first,
  output logic                        tap_last,
  output logic                        win_first,
  output logic                        win_last
);

  localparam int CW = $clog2(IMG_SIZE);
  localparam logic [CW-1:0] IMG_MAX = CW'(IMG_SIZE - 1);
  localparam logic [CW-1:0] WIN_MAX = CW'(IMG_SIZE - 6);
  localparam logic [2:0]    K_MAX   = 3'(K_SIZE - 1);

  ctrl_state_t state, state_nxt;

  logic [CW-1:0] col_max;
  logic [CW-1:0] win_row;
  logic [CW-1:0] win_col;
  // Position in pool window: bit 1 is row offset, bit 0 column offset
  logic [1:0]    pos;
  logic          in_xfer;
  logic          res_xfer;
  logic          load_done;
  logic          read_done;
  logic          last_win;
  // Flags are {tap_valid, tap_first, tap_last, win_first, win_last}
  logic [4:0]    flags_s0;
  logic [4:0]    flags_d1;
  logic [4:0]    flags_d2;

  assign in_ready = (state == ST_IDLE) || (state == ST_LOAD_IMG) ||
                    (state == ST_LOAD_KER);
  assign in_xfer  = in_valid && in_ready;
  assign res_xfer = res_valid && res_ready;
  assign wr_en    = in_xfer;
  assign wr_ker   = (state == ST_LOAD_KER);

  // Kernel rows are 5 wide, image rows IMG_SIZE wide
  assign col_max   = wr_ker ? CW'(K_MAX) : IMG_MAX;
  assign load_done = (wr_row == col_max) && (wr_col == col_max);
  assign read_done = (pos == 2'd3) && (ker_row == K_MAX);
  assign last_win  = (win_row == WIN_MAX) && (win_col == WIN_MAX);

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (in_xfer) state_nxt = ST_LOAD_IMG;
      ST_LOAD_IMG:
        if (in_xfer && load_done) state_nxt = ST_LOAD_KER;
      ST_LOAD_KER:
        if (in_xfer && load_done) state_nxt = ST_CONV;
      ST_CONV:
        if (read_done) state_nxt = ST_WAIT_RES;
      ST_WAIT_RES:
        if (res_xfer) state_nxt = last_win ? ST_IDLE : ST_CONV;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // --------------------------------------------------------------------------
  // Load counters, row-major
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_row <= '0;
      wr_col <= '0;
    end
    else if (in_xfer)
    begin
      if (wr_col == col_max)
      begin
        wr_col <= '0;
        wr_row <= load_done ? '0 : wr_row + 1'b1;
      end
      else
        wr_col <= wr_col + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Window scan: 4 positions x 5 kernel rows per pool window
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ker_row <= '0;
      pos     <= '0;
      win_row <= '0;
      win_col <= '0;
    end
    else if (state == ST_CONV)
    begin
      if (ker_row == K_MAX)
      begin
        ker_row <= '0;
        pos     <= pos + 1'b1;
      end
      else
        ker_row <= ker_row + 1'b1;
    end
    else if (state == ST_WAIT_RES && res_xfer)
    begin
      // Next window in raster order, stride 2
      if (last_win)
      begin
        win_row <= '0;
        win_col <= '0;
      end
      else if (win_col == WIN_MAX)
      begin
        win_col <= '0;
        win_row <= win_row + CW'(2);
      end
      else
        win_col <= win_col + CW'(2);
    end
  end

  assign rd_row = win_row + CW'(pos[1]) + CW'(ker_row);
  assign rd_col = win_col + CW'(pos[0]);

  // Two-stage delay puts the flags beside the product-sum register
  assign flags_s0 = {state == ST_CONV, ker_row == 3'd0, ker_row == K_MAX,
                     pos == 2'd0, pos == 2'd3};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      flags_d1 <= '0;
      flags_d2 <= '0;
    end
    else
    begin
      flags_d1 <= flags_s0;
      flags_d2 <= flags_d1;
    end
  end

  assign {tap_valid, tap_first, tap_last, win_first, win_last} = flags_d2;

endmodule

// File: source/conv_pool.sv
// Five-tap MAC with row accumulation and 2x2 max pooling
// One kernel row per cycle; five rows make one convolution value and four
// values feed a running maximum that is handed off with valid/ready

`timescale 1ns/1ps

module conv_pool import cad_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  pix_t img_row      [K_SIZE],
  input  pix_t ker_row_data [K_SIZE],
  input  logic tap_valid,
  input  logic tap_first,
  input  logic tap_last,
  input  logic win_first,
  input  logic win_last,
  input  logic res_ready,
  output logic res_valid,
  output acc_t res_data
);

  acc_t prod_sum;
  acc_t psum_q;
  acc_t acc_q;
  acc_t max_q;
  acc_t conv_sum;

  // --------------------------------------------------------------------------
  // Row product sum
  // --------------------------------------------------------------------------
  // Operands are sign extended before the multiply
  always_comb
  begin
    prod_sum = '0;
    for (int k = 0; k < K_SIZE; k++)
    begin
      prod_sum = prod_sum + acc_t'(img_row[k]) * acc_t'(ker_row_data[k]);
    end
  end

  always_ff @(posedge clk)
  begin
    psum_q <= prod_sum;
  end

  // Full 5x5 sum when tap_last is set
  assign conv_sum = acc_q + psum_q;

  // --------------------------------------------------------------------------
  // Row accumulation and running maximum
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (tap_valid)
    begin
      acc_q <= tap_first ? psum_q : conv_sum;
      if (tap_last && (win_first || conv_sum > max_q))
        max_q <= conv_sum;
    end
  end

  // Result stays put until the serializer takes it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      res_valid <= 1'b0;
    else if (tap_valid && tap_last && win_last)
      res_valid <= 1'b1;
    else if (res_ready)
      res_valid <= 1'b0;
  end

  assign res_data = max_q;

endmodule

// File: source/result_serializer.sv
// Bit-serial result output
// Takes one pooled result when empty and shifts it out LSB first,
// one bit per accepted out_valid/out_ready beat

`timescale 1ns/1ps

module result_serializer import cad_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic res_valid,
  input  acc_t res_data,
  input  logic out_ready,
  output logic res_ready,
  output logic out_valid,
  output logic out_bit
);

  localparam int CNT_W = $clog2(ACC_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(ACC_W - 1);

  logic [ACC_W-1:0] shift_q;
  logic [CNT_W-1:0] bit_cnt;
  logic             busy;

  assign res_ready = !busy;
  assign out_valid = busy;
  assign out_bit   = shift_q[0];

  // Busy flag and bit counter
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
    end
    else if (res_valid && res_ready)
    begin
      busy    <= 1'b1;
      bit_cnt <= '0;
    end
    else if (out_valid && out_ready)
    begin
      if (bit_cnt == LAST_BIT)
        busy <= 1'b0;
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Shift register, bit 0 is on the wire
  always_ff @(posedge clk)
  begin
    if (res_valid && res_ready)
      shift_q <= res_data;
    else if (out_valid && out_ready)
      shift_q <= shift_q >> 1;
  end

endmodule

// File: source/cad_top.sv
// Convolution engine top level
// Loads one image and one 5x5 kernel, computes the valid convolution with
// 2x2 max pooling and sends each pooled result out bit-serially

`timescale 1ns/1ps

module cad_top import cad_pkg::*; #(
  parameter int IMG_SIZE = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  pix_t in_data,
  output logic in_ready,
  output logic out_valid,
  output logic out_bit,
  input  logic out_ready
);

  localparam int CW = $clog2(IMG_SIZE);

  // Buffer control
  logic          wr_en;
  logic          wr_ker;
  logic [CW-1:0] wr_row;
  logic [CW-1:0] wr_col;
  logic [CW-1:0] rd_row;
  logic [CW-1:0] rd_col;
  logic [2:0]    ker_row;
  pix_t          img_row      [K_SIZE];
  pix_t          ker_row_data [K_SIZE];

  // MAC control and result hand-off
  logic tap_valid;
  logic tap_first;
  logic tap_last;
  logic win_first;
  logic win_last;
  logic res_valid;
  logic res_ready;
  acc_t res_data;

  cad_ctrl #(
    .IMG_SIZE (IMG_SIZE)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .in_ready  (in_ready),
    .wr_en     (wr_en),
    .wr_ker    (wr_ker),
    .wr_row    (wr_row),
    .wr_col    (wr_col),
    .rd_row    (rd_row),
    .rd_col    (rd_col),
    .ker_row   (ker_row),
    .tap_valid (tap_valid),
    .tap_first (tap_first),
    .tap_last  (tap_last),
    .win_first (win_first),
    .win_last  (win_last)
  );

  cad_buffer #(
    .IMG_SIZE (IMG_SIZE)
  ) u_buffer (
    .clk          (clk),
    .in_data      (in_data),
    .wr_en        (wr_en),
    .wr_ker       (wr_ker),
    .wr_row       (wr_row),
    .wr_col       (wr_col),
    .rd_row       (rd_row),
    .rd_col       (rd_col),
    .ker_row      (ker_row),
    .img_row      (img_row),
    .ker_row_data (ker_row_data)
  );

  conv_pool u_conv_pool (
    .clk          (clk),
    .rst_n        (rst_n),
    .img_row      (img_row),
    .ker_row_data (ker_row_data),
    .tap_valid    (tap_valid),
    .tap_first    (tap_first),
    .tap_last     (tap_last),
    .win_first    (win_first),
    .win_last     (win_last),
    .res_ready    (res_ready),
    .res_valid    (res_valid),
    .res_data     (res_data)
  );

  result_serializer u_serializer (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res_data  (res_data),
    .out_ready (out_ready),
    .res_ready (res_ready),
    .out_valid (out_valid),
    .out_bit   (out_bit)
  );

endmodule

// File: testbench/tb_cad_model.svh
// Reference model for the convolution engine testbench
// Galois LFSR bit source and golden 5x5 convolution with 2x2 max pooling
// over the testbench image and kernel arrays

`ifndef TB_CAD_MODEL_SVH
`define TB_CAD_MODEL_SVH

  // --------------------------------------------------------------------------
  // Galois LFSR, 32 bits, one step per bit taken
  // --------------------------------------------------------------------------
  logic [31:0] lfsr_state = 32'h7014_4cdb;

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 32'hD000_0001;
    return out;
  endfunction

  // First bit taken ends up in the highest position
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // --------------------------------------------------------------------------
  // Golden convolution and pooling
  // --------------------------------------------------------------------------
  // Valid 5x5 sum with the kernel's top-left corner at (r, c)
  function automatic int conv_at(input int r, input int c);
    int s;
    s = 0;
    for (int i = 0; i < K_SIZE; i++)
    begin
      for (int j = 0; j < K_SIZE; j++)
      begin
        s = s + img_arr[r + i][c + j] * ker_arr[i][j];
      end
    end
    return s;
  endfunction

  // Max of the four sums of the pool window at convolution position (r, c)
  function automatic int pool_at(input int r, input int c);
    int best;
    int v;
    best = conv_at(r, c);
    for (int p = 1; p < 4; p++)
    begin
      v = conv_at(r + p / 2, c + p % 2);
      if (v > best)
        best = v;
    end
    return best;
  endfunction

`endif

// File: testbench/tb_cad.sv
// Testbench for the convolution engine
// Runs a table of jobs through the byte stream, collects the serial output
// into words and compares them with the golden model

`timescale 1ns/1ps

module tb_cad
  import cad_pkg::*;
();

  localparam int IMG_SIZE = 8;
  localparam int CLK_HALF = 50;
  localparam int N_SIDE   = (IMG_SIZE - 4) / 2;
  localparam int N_WIN    = N_SIDE * N_SIDE;
  localparam int N_BYTES  = IMG_SIZE * IMG_SIZE + K_SIZE * K_SIZE;

  // Fill kinds
  localparam logic [2:0] FILL_RANDOM = 3'd0;
  localparam logic [2:0] FILL_ONES   = 3'd1;
  localparam logic [2:0] FILL_RAMP   = 3'd2;
  localparam logic [2:0] FILL_MIN    = 3'd3;
  localparam logic [2:0] FILL_MAX    = 3'd4;
  // Reuse the arrays of the previous job
  localparam logic [2:0] FILL_KEEP   = 3'd5;

  typedef struct packed {
    logic [2:0] img_kind;
    logic [2:0] ker_kind;
    logic       rdy_random;
    logic       in_gaps;
  } job_t;

  // ------------------------------------------------------------------------
  // Job table: image fill, kernel fill, random out_ready, in_valid gaps
  // ------------------------------------------------------------------------
  localparam int N_JOBS = 7;
  localparam job_t JOB_TABLE [N_JOBS] = '{
    '{FILL_RANDOM, FILL_RANDOM, 1'b0, 1'b0},
    '{FILL_KEEP,   FILL_KEEP,   1'b1, 1'b1},
    '{FILL_MIN,    FILL_MIN,    1'b0, 1'b0},
    '{FILL_MIN,    FILL_MAX,    1'b0, 1'b0},
    '{FILL_MAX,    FILL_MIN,    1'b1, 1'b1},
    '{FILL_RANDOM, FILL_RANDOM, 1'b1, 1'b1},
    '{FILL_RAMP,   FILL_ONES,   1'b0, 1'b1}
  };

  localparam int WATCHDOG_CYCLES =
    N_JOBS * (N_BYTES + N_WIN * (20 + 3 + ACC_W)) * 4 + 100;

  logic clk;
  logic rst_n;
  logic in_valid;
  pix_t in_data;
  logic in_ready;
  logic out_valid;
  logic out_bit;
  logic out_ready;

  int               img_arr [IMG_SIZE][IMG_SIZE];
  int               ker_arr [K_SIZE][K_SIZE];
  logic [ACC_W-1:0] exp_q [$];
  logic [ACC_W-1:0] cap_word;
  int               cap_pos;
  int               words_got;
  int               words_target;
  logic             rdy_random;

  `include "tb_cad_model.svh"

  cad_top #(
    .IMG_SIZE (IMG_SIZE)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_bit   (out_bit),
    .out_ready (out_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic report_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  function automatic int fill_value(input logic [2:0] kind, input int r, input int c,
                                    input int side);
    logic [7:0] raw;
    case (kind)
      FILL_RANDOM: raw = 8'(lfsr_bits(8));
      FILL_ONES:   raw = 8'd1;
      FILL_RAMP:   raw = 8'(r * side + c);
      FILL_MIN:    raw = 8'h80;
      default:     raw = 8'h7f;
    endcase
    return int'($signed(raw));
  endfunction

  // Stream position to byte, image first then kernel
  function automatic pix_t byte_at(input int idx);
    int k;
    if (idx < IMG_SIZE * IMG_SIZE)
      return pix_t'(img_arr[idx / IMG_SIZE][idx % IMG_SIZE]);
    k = idx - IMG_SIZE * IMG_SIZE;
    return pix_t'(ker_arr[k / K_SIZE][k % K_SIZE]);
  endfunction

  task automatic prepare_job(input job_t job);
    for (int r = 0; r < IMG_SIZE; r++)
    begin
      for (int c = 0; c < IMG_SIZE; c++)
      begin
        if (job.img_kind != FILL_KEEP)
          img_arr[r][c] = fill_value(job.img_kind, r, c, IMG_SIZE);
      end
    end
    for (int r = 0; r < K_SIZE; r++)
    begin
      for (int c = 0; c < K_SIZE; c++)
      begin
        if (job.ker_kind != FILL_KEEP)
          ker_arr[r][c] = fill_value(job.ker_kind, r, c, K_SIZE);
      end
    end
    // Pool windows in raster order
    for (int wr = 0; wr < N_SIDE; wr++)
    begin
      for (int wc = 0; wc < N_SIDE; wc++)
      begin
        exp_q.push_back(ACC_W'(pool_at(2 * wr, 2 * wc)));
      end
    end
    words_target = words_target + N_WIN;
  endtask

  // Next drive point, 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
    out_ready = rdy_random ? lfsr_bit() : 1'b1;
  endtask

  task automatic run_job(input int j);
    job_t job;
    int   idx;
    job = JOB_TABLE[j];
    prepare_job(job);
    rdy_random = job.rdy_random;
    idx = 0;
    while (idx < N_BYTES)
    begin
      in_data  = byte_at(idx);
      in_valid = job.in_gaps ? lfsr_bit() : 1'b1;
      @(negedge clk);
      if (in_valid && in_ready)
        idx++;
      step_cycle();
    end
    in_valid = 1'b0;
    in_data  = '0;
    // Controller stays busy until the last result is in the serializer
    while (words_got < words_target)
    begin
      @(negedge clk);
      assert (!in_ready || words_got >= words_target - 1)
      else
      begin
        $display("in_ready rose in job %0d before its last result was accepted", j);
        report_failure();
      end
      step_cycle();
    end
  endtask

  task automatic check_word();
    logic [ACC_W-1:0] exp_word;
    assert (exp_q.size() > 0)
    else
    begin
      $display("Output word %0d arrived with no result expected", words_got);
      report_failure();
    end
    exp_word = exp_q.pop_front();
    assert (cap_word == exp_word)
    else
    begin
      $display("Mismatch at %0t: word %0d got %0d expected %0d", $time, words_got,
               $signed(cap_word), $signed(exp_word));
      report_failure();
    end
    words_got++;
    cap_pos = 0;
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial
  begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    out_ready    = 1'b0;
    rdy_random   = 1'b0;
    cap_word     = '0;
    cap_pos      = 0;
    words_got    = 0;
    words_target = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (in_ready === 1'b1 && out_valid === 1'b0)
    else
    begin
      $display("After reset in_ready is not high or out_valid is not low");
      report_failure();
    end
    step_cycle();
    for (int j = 0; j < N_JOBS; j++)
    begin
      run_job(j);
    end
    // No stray bits once every job is done
    rdy_random = 1'b0;
    out_ready  = 1'b1;
    repeat (2 * ACC_W)
    begin
      @(negedge clk);
      assert (!out_valid)
      else
      begin
        $display("out_valid high after the last expected word");
        report_failure();
      end
    end
    if (exp_q.size() == 0 && cap_pos == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("Run ended with %0d words and %0d bits still pending", exp_q.size(), cap_pos);
      report_failure();
    end
  end

  // --------------------------------------------------------------------------
  // Output capture, LSB first
  // --------------------------------------------------------------------------
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (rst_n && out_valid && out_ready)
      begin
        cap_word = {out_bit, cap_word[ACC_W-1:1]};
        cap_pos++;
        if (cap_pos == ACC_W)
          check_word();
      end
    end
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    report_failure();
  end

endmodule

// File: sim.f
+incdir+testbench
source/cad_pkg.sv
source/cad_buffer.sv
source/cad_ctrl.sv
source/conv_pool.sv
source/result_serializer.sv
source/cad_top.sv
testbench/tb_cad.sv

// File: Makefile
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_cad
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard source/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
